/* list.f */
src/game_pkg.sv
src/score_pkg.sv
src/cycle_steer.sv
src/trail_arena.sv
src/score_keeper.sv
src/game_control.sv
src/light_cycle_top.sv
tb/light_cycle_tb.sv

/* Makefile */
# Verilator build for the light-cycle game

TOP := light_cycle_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/light_cycle_tb.sv */
// Light-cycle game testbench
// Directed tests against a reference model of the arena, the crash rules
// and the match scoring.

module light_cycle_tb
	import game_pkg::*;
	import score_pkg::*;
();

	logic Clk;
	logic rst_n;
	logic frame_tick;
	logic start;
	logic red_turn;
	logic blue_turn;
	dir_t red_dir;
	dir_t blue_dir;
	logic [SCORE_BITS-1:0] score_red;
	logic [SCORE_BITS-1:0] score_blue;
	logic red_wins;
	logic blue_wins;
	logic round_over;
	game_state_t game_state;

	// reference model of cycles, grid and match
	logic [ARENA_BITS-1:0] m_rx;
	logic [ARENA_BITS-1:0] m_ry;
	logic [ARENA_BITS-1:0] m_bx;
	logic [ARENA_BITS-1:0] m_by;
	dir_t m_rhead;
	dir_t m_rreq;
	dir_t m_bhead;
	dir_t m_breq;
	logic [ARENA_CELLS-1:0] occ;
	logic [SCORE_BITS-1:0] m_red_pts;
	logic [SCORE_BITS-1:0] m_blue_pts;
	logic m_red_wins;
	logic m_blue_wins;
	game_state_t m_state;
	logic [1:0] m_pause;
	logic m_crash;
	logic m_red_crash;
	logic m_blue_crash;
	integer seed;

	light_cycle_top DUT (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.frame_tick (frame_tick),
		.start      (start),
		.red_turn   (red_turn),
		.blue_turn  (blue_turn),
		.red_dir    (red_dir),
		.blue_dir   (blue_dir),
		.score_red  (score_red),
		.score_blue (score_blue),
		.red_wins   (red_wins),
		.blue_wins  (blue_wins),
		.round_over (round_over),
		.game_state (game_state)
	);

	always #20 Clk = ~Clk;

	task automatic check(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("[ERROR] %0t: %s", $time, what);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic give_up(input string why);
		$display("timeout: %s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	function automatic dir_t reverse_of(input dir_t d);
		case (d)
			north:   return south;
			south:   return north;
			east:    return west;
			default: return east;
		endcase
	endfunction

	// one cell along d with wrap at every edge
	task automatic advance(inout logic [ARENA_BITS-1:0] x, inout logic [ARENA_BITS-1:0] y,
		input dir_t d);
		case (d)
			north:   y = y - ARENA_BITS'(1);
			east:    x = x + ARENA_BITS'(1);
			south:   y = y + ARENA_BITS'(1);
			default: x = x - ARENA_BITS'(1);
		endcase
	endtask

	task automatic clear_model_arena();
		m_rx = RED_START_X;
		m_ry = START_Y;
		m_bx = BLUE_START_X;
		m_by = START_Y;
		m_rhead = RED_START_DIR;
		m_rreq = RED_START_DIR;
		m_bhead = BLUE_START_DIR;
		m_breq = BLUE_START_DIR;
		occ = '0;
	endtask

	// expected effect of one frame tick on the model
	task automatic predict_tick();
		logic same;
		m_crash = 1'b0;
		if (m_state == play)
		begin
			m_rhead = m_rreq;
			m_bhead = m_breq;
			advance(m_rx, m_ry, m_rhead);
			advance(m_bx, m_by, m_bhead);
			same = m_rx == m_bx && m_ry == m_by;
			m_red_crash = occ[{m_ry, m_rx}] || same;
			m_blue_crash = occ[{m_by, m_bx}] || same;
			occ[{m_ry, m_rx}] = 1'b1;
			occ[{m_by, m_bx}] = 1'b1;
			m_crash = m_red_crash || m_blue_crash;
			// the survivor of a single crash scores
			if (m_blue_crash && !m_red_crash)
			begin
				m_red_pts = m_red_pts + SCORE_BITS'(1);
				if (m_red_pts == WIN_POINTS)
					m_red_wins = 1'b1;
			end
			if (m_red_crash && !m_blue_crash)
			begin
				m_blue_pts = m_blue_pts + SCORE_BITS'(1);
				if (m_blue_pts == WIN_POINTS)
					m_blue_wins = 1'b1;
			end
			if (m_crash)
			begin
				m_pause = 2'd0;
				m_state = (m_red_wins || m_blue_wins) ? match_end : round_end;
			end
		end
		else if (m_state == round_end)
		begin
			m_pause = m_pause + 2'd1;
			if (m_pause == ROUND_PAUSE)
			begin
				m_state = play;
				clear_model_arena();
			end
		end
	endtask

	// tick pulse plus five quiet cycles; round_over is due two edges after the tick edge
	task automatic frame_step();
		int i;
		frame_tick = 1'b1;
		predict_tick();
		for (i = 1; i <= 6; i++)
		begin
			@(negedge Clk);
			frame_tick = 1'b0;
			check(round_over == (i == 3 && m_crash),
				$sformatf("round_over is %b %0d edges after the tick edge", round_over, i - 1));
		end
		check(game_state == m_state,
			$sformatf("game_state is %0d, model has %0d", game_state, m_state));
		check(score_red == m_red_pts && score_blue == m_blue_pts,
			$sformatf("scores %0d:%0d, model has %0d:%0d", score_red, score_blue,
				m_red_pts, m_blue_pts));
		check(red_wins == m_red_wins && blue_wins == m_blue_wins, "win flags differ from model");
	endtask

	task automatic steer(input logic is_red, input dir_t d);
		if (is_red)
		begin
			red_turn = 1'b1;
			red_dir = d;
			if (d != reverse_of(m_rhead))
				m_rreq = d;
		end
		else
		begin
			blue_turn = 1'b1;
			blue_dir = d;
			if (d != reverse_of(m_bhead))
				m_breq = d;
		end
		@(negedge Clk);
		red_turn = 1'b0;
		blue_turn = 1'b0;
	endtask

	task automatic wait_for_state(input game_state_t want, input int limit);
		int k;
		k = 0;
		while (game_state != want)
		begin
			if (k == limit)
				give_up($sformatf("game_state never reached %0d in %0d cycles", want, limit));
			@(negedge Clk);
			k++;
		end
	endtask

	task automatic press_start();
		start = 1'b1;
		@(negedge Clk);
		start = 1'b0;
		wait_for_state(play, 4);
		// clear pulses act on the edge after the state change
		@(negedge Clk);
		m_state = play;
		m_red_pts = '0;
		m_blue_pts = '0;
		m_red_wins = 1'b0;
		m_blue_wins = 1'b0;
		clear_model_arena();
		check(score_red == '0 && score_blue == '0 && !red_wins && !blue_wins,
			"scores or win flags not cleared by start");
	endtask

	// ticks until the model sees a crash, optionally with random legal turns
	task automatic play_round(input logic random_turns, output int ticks);
		logic [31:0] r;
		ticks = 0;
		m_crash = 1'b0;
		while (!m_crash)
		begin
			// a full grid forces a crash well before 200 ticks
			if (ticks == 200)
				give_up("round did not end within 200 ticks");
			if (random_turns)
			begin
				r = $random(seed);
				if (r[2:0] == 3'd0 && dir_t'(r[5:4]) != reverse_of(m_rhead))
					steer(1'b1, dir_t'(r[5:4]));
				if (r[10:8] == 3'd0 && dir_t'(r[13:12]) != reverse_of(m_bhead))
					steer(1'b0, dir_t'(r[13:12]));
			end
			frame_step();
			ticks++;
		end
	endtask

	// pause ticks of round_end unless the match is over
	task automatic finish_round();
		if (m_state == round_end)
		begin
			frame_step();
			frame_step();
			check(game_state == play, "game did not resume after the round pause");
		end
	endtask

	// blue loops west, north, west, south, east back onto its first cell
	task automatic square_round(output int ticks);
		int rest;
		frame_step();
		steer(1'b0, north);
		frame_step();
		steer(1'b0, west);
		frame_step();
		steer(1'b0, south);
		frame_step();
		steer(1'b0, east);
		play_round(1'b0, rest);
		ticks = 4 + rest;
	endtask

	task automatic reset_and_start();
		check(game_state == idle, "game_state not idle after reset");
		check(score_red == '0 && score_blue == '0, "scores not zero after reset");
		check(round_over == 1'b0, "round_over high after reset");
		press_start();
	endtask

	task automatic head_on_draw();
		int ticks;
		play_round(1'b0, ticks);
		check(ticks == 6, $sformatf("head-on crash on tick %0d", ticks));
		check(m_red_crash && m_blue_crash, "head-on crash not a double crash");
		check(score_red == '0 && score_blue == '0, "a draw changed the scores");
		finish_round();
	endtask

	task automatic blue_square();
		int ticks;
		// exact reverse of west must be ignored
		steer(1'b0, east);
		square_round(ticks);
		check(ticks == 5, $sformatf("blue crashed on tick %0d", ticks));
		check(score_red == 2'd1 && score_blue == 2'd0, "blue's own crash did not score red");
		finish_round();
	endtask

	task automatic random_rounds();
		int rounds;
		int ticks;
		rounds = 0;
		while (m_state != match_end && rounds < 8)
		begin
			play_round(1'b1, ticks);
			finish_round();
			rounds++;
		end
	endtask

	task automatic red_match_win();
		int rounds;
		int ticks;
		if (m_state == match_end)
			press_start();
		rounds = 0;
		while (!m_red_wins)
		begin
			if (rounds == 4)
				give_up("red did not win within 4 rounds");
			square_round(ticks);
			finish_round();
			rounds++;
		end
		check(red_wins && score_red == WIN_POINTS, "red_wins not raised at three points");
		check(game_state == match_end, "game_state not match_end after the win");
		// a finished match ignores frame ticks
		frame_step();
		frame_step();
		frame_step();
		press_start();
	endtask

	initial
	begin
		seed = 32'hc28e;
		Clk = 1'b0;
		rst_n = 1'b0;
		frame_tick = 1'b0;
		start = 1'b0;
		red_turn = 1'b0;
		blue_turn = 1'b0;
		red_dir = east;
		blue_dir = west;
		m_state = idle;
		m_red_pts = '0;
		m_blue_pts = '0;
		m_red_wins = 1'b0;
		m_blue_wins = 1'b0;
		m_pause = 2'd0;
		m_crash = 1'b0;
		clear_model_arena();
		repeat (3) @(negedge Clk);
		rst_n = 1'b1;

		reset_and_start();
		head_on_draw();
		blue_square();
		random_rounds();
		red_match_win();

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* src/light_cycle_top.sv */
// Light-cycle game top
// Steering, trail arena and score keeper in a valid/ready pipeline,
// sequenced by the game controller.

// move record from steering to the arena
interface move_if
	import game_pkg::*;
();
	logic valid;
	logic ready;
	logic [ARENA_BITS-1:0] red_x;
	logic [ARENA_BITS-1:0] red_y;
	logic [ARENA_BITS-1:0] blue_x;
	logic [ARENA_BITS-1:0] blue_y;

	modport src (output valid, red_x, red_y, blue_x, blue_y, input ready);
	modport dst (input valid, red_x, red_y, blue_x, blue_y, output ready);
endinterface

// crash record from the arena to scoring
interface crash_if;
	logic valid;
	logic ready;
	logic red_crash;
	logic blue_crash;

	modport src (output valid, red_crash, blue_crash, input ready);
	modport dst (input valid, red_crash, blue_crash, output ready);
endinterface

module light_cycle_top
	import game_pkg::*;
	import score_pkg::*;
(
	input  logic                  Clk,
	input  logic                  rst_n,
	input  logic                  frame_tick,
	input  logic                  start,
	input  logic                  red_turn,
	input  logic                  blue_turn,
	input  dir_t                  red_dir,
	input  dir_t                  blue_dir,
	output logic [SCORE_BITS-1:0] score_red,
	output logic [SCORE_BITS-1:0] score_blue,
	output logic                  red_wins,
	output logic                  blue_wins,
	output logic                  round_over,
	output game_state_t           game_state
);

	logic playing;
	logic round_clear;
	logic match_clear;

	move_if mv ();
	crash_if cr ();

	cycle_steer u_steer (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.frame_tick  (frame_tick),
		.playing     (playing),
		.round_clear (round_clear),
		.red_turn    (red_turn),
		.blue_turn   (blue_turn),
		.red_dir     (red_dir),
		.blue_dir    (blue_dir),
		.move        (mv)
	);

	trail_arena u_arena (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.round_clear (round_clear),
		.move        (mv),
		.crash       (cr)
	);

	score_keeper u_score (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.match_clear (match_clear),
		.crash       (cr),
		.score_red   (score_red),
		.score_blue  (score_blue),
		.red_wins    (red_wins),
		.blue_wins   (blue_wins),
		.round_over  (round_over)
	);

	game_control u_control (
		.Clk         (Clk),
		.rst_n       (rst_n),
		.start       (start),
		.frame_tick  (frame_tick),
		.round_over  (round_over),
		.red_wins    (red_wins),
		.blue_wins   (blue_wins),
		.game_state  (game_state),
		.playing     (playing),
		.round_clear (round_clear),
		.match_clear (match_clear)
	);

endmodule

/* src/game_control.sv */
// Game control
// Four-state game sequencer. Starts matches, pauses between rounds and
// issues the clear pulses for the arena, the cycles and the scores.

module game_control
	import game_pkg::*;
	import score_pkg::*;
(
	input  logic        Clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        frame_tick,
	input  logic        round_over,
	input  logic        red_wins,
	input  logic        blue_wins,
	output game_state_t game_state,
	output logic        playing,
	output logic        round_clear,
	output logic        match_clear
);

	// frame ticks seen so far in round_end
	logic [1:0] pause_cnt;
	logic pause_done;

	assign playing = game_state == play;
	assign pause_done = pause_cnt == ROUND_PAUSE - 2'd1;

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			game_state <= idle;
			pause_cnt <= 2'd0;
			round_clear <= 1'b0;
			match_clear <= 1'b0;
		end
		else
		begin
			round_clear <= 1'b0;
			match_clear <= 1'b0;
			case (game_state)
				idle, match_end:
				begin
					// a new match also clears the arena and the cycles
					if (start)
					begin
						game_state <= play;
						match_clear <= 1'b1;
						round_clear <= 1'b1;
					end
				end
				play:
				begin
					if (round_over)
					begin
						game_state <= (red_wins || blue_wins) ? match_end : round_end;
						pause_cnt <= 2'd0;
					end
				end
				default:
				begin
					if (frame_tick && pause_done)
					begin
						game_state <= play;
						round_clear <= 1'b1;
						pause_cnt <= 2'd0;
					end
					else if (frame_tick)
						pause_cnt <= pause_cnt + 2'd1;
				end
			endcase
		end
	end

endmodule

/* src/score_keeper.sv */
// Score keeper
// Turns crash records into round points, flags the end of each round and
// holds the match winner until the next match starts.

module score_keeper
	import score_pkg::*;
(
	input  logic                  Clk,
	input  logic                  rst_n,
	input  logic                  match_clear,
	crash_if.dst                  crash,
	output logic [SCORE_BITS-1:0] score_red,
	output logic [SCORE_BITS-1:0] score_blue,
	output logic                  red_wins,
	output logic                  blue_wins,
	output logic                  round_over
);

	logic take;
	logic decided;
	logic any_crash;
	logic red_point;
	logic blue_point;
	logic [SCORE_BITS-1:0] red_sum;
	logic [SCORE_BITS-1:0] blue_sum;

	// scoring never stalls the arena
	assign crash.ready = 1'b1;
	assign take = crash.valid && crash.ready;

	// once a winner is known the match is frozen
	assign decided = red_wins || blue_wins;
	assign any_crash = crash.red_crash || crash.blue_crash;

	// the point goes to whoever is still riding, a double crash is a draw
	assign red_point = take && !decided && crash.blue_crash && !crash.red_crash;
	assign blue_point = take && !decided && crash.red_crash && !crash.blue_crash;

	assign red_sum = score_red + SCORE_BITS'(1);
	assign blue_sum = score_blue + SCORE_BITS'(1);

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			score_red <= '0;
			score_blue <= '0;
			red_wins <= 1'b0;
			blue_wins <= 1'b0;
			round_over <= 1'b0;
		end
		else if (match_clear)
		begin
			score_red <= '0;
			score_blue <= '0;
			red_wins <= 1'b0;
			blue_wins <= 1'b0;
			round_over <= 1'b0;
		end
		else
		begin
			// one-cycle pulse, only for records that hold a crash
			round_over <= take && !decided && any_crash;
			if (red_point)
			begin
				score_red <= red_sum;
				if (red_sum == WIN_POINTS)
					red_wins <= 1'b1;
			end
			if (blue_point)
			begin
				score_blue <= blue_sum;
				if (blue_sum == WIN_POINTS)
					blue_wins <= 1'b1;
			end
		end
	end

endmodule

/* src/trail_arena.sv */
// Trail arena
// Occupancy grid of the 16 by 16 arena. Tests both new heads against the
// trails laid so far, marks them and passes on a crash record.

module trail_arena
	import game_pkg::*;
(
	input  logic Clk,
	input  logic rst_n,
	input  logic round_clear,
	move_if.dst  move,
	crash_if.src crash
);

	// one bit per cell, indexed by {y, x}
	logic [ARENA_CELLS-1:0] occupied;
	logic [2*ARENA_BITS-1:0] red_cell;
	logic [2*ARENA_BITS-1:0] blue_cell;
	logic take;
	logic same_cell;
	logic red_hit;
	logic blue_hit;

	assign red_cell = {move.red_y, move.red_x};
	assign blue_cell = {move.blue_y, move.blue_x};

	// the single output slot frees up when it is empty or draining
	assign move.ready = !crash.valid || crash.ready;
	assign take = move.valid && move.ready;

	// head-on into the same cell takes out both cycles
	assign same_cell = red_cell == blue_cell;
	assign red_hit = occupied[red_cell] || same_cell;
	assign blue_hit = occupied[blue_cell] || same_cell;

	// grid update and slot valid
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			occupied <= '0;
			crash.valid <= 1'b0;
		end
		else if (round_clear)
		begin
			occupied <= '0;
			crash.valid <= 1'b0;
		end
		else if (take)
		begin
			// mark after the test, so a head never hits itself
			occupied[red_cell] <= 1'b1;
			occupied[blue_cell] <= 1'b1;
			crash.valid <= 1'b1;
		end
		else if (crash.ready)
		begin
			crash.valid <= 1'b0;
		end
	end

	// record payload, loaded with the move
	always_ff @(posedge Clk)
	begin
		if (take)
		begin
			crash.red_crash <= red_hit;
			crash.blue_crash <= blue_hit;
		end
	end

endmodule

/* src/cycle_steer.sv */
// Cycle steering
// Holds heading and head position of both cycles and emits one move
// record on every frame tick accepted while the game is playing.

module cycle_steer
	import game_pkg::*;
(
	input  logic Clk,
	input  logic rst_n,
	input  logic frame_tick,
	input  logic playing,
	input  logic round_clear,
	input  logic red_turn,
	input  logic blue_turn,
	input  dir_t red_dir,
	input  dir_t blue_dir,
	move_if.src  move
);

	// heading of the last step taken
	dir_t red_head;
	dir_t blue_head;
	// heading for the next step
	dir_t red_req;
	dir_t blue_req;
	dir_t red_cur;
	dir_t blue_cur;
	logic [ARENA_BITS-1:0] red_x;
	logic [ARENA_BITS-1:0] red_y;
	logic [ARENA_BITS-1:0] blue_x;
	logic [ARENA_BITS-1:0] blue_y;
	logic [2*ARENA_BITS-1:0] red_next;
	logic [2*ARENA_BITS-1:0] blue_next;
	logic tick_ok;

	function automatic dir_t opposite(input dir_t d);
		return dir_t'(d ^ 2'b10);
	endfunction

	// one cell in heading d, wrapping modulo 16; result is {x, y}
	function automatic logic [2*ARENA_BITS-1:0] step(
		input logic [ARENA_BITS-1:0] x,
		input logic [ARENA_BITS-1:0] y,
		input dir_t d
	);
		logic [ARENA_BITS-1:0] nx;
		logic [ARENA_BITS-1:0] ny;
		nx = x;
		ny = y;
		case (d)
			north:   ny = y - ARENA_BITS'(1);
			east:    nx = x + ARENA_BITS'(1);
			south:   ny = y + ARENA_BITS'(1);
			default: nx = x - ARENA_BITS'(1);
		endcase
		return {nx, ny};
	endfunction

	// ticks that land while a move is still pending are dropped
	assign tick_ok = frame_tick && playing && !move.valid;

	// heading that is current once this edge has passed
	assign red_cur = tick_ok ? red_req : red_head;
	assign blue_cur = tick_ok ? blue_req : blue_head;

	assign red_next = step(red_x, red_y, red_req);
	assign blue_next = step(blue_x, blue_y, blue_req);

	// turn requests, a reversal into the own trail is ignored
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			red_req <= RED_START_DIR;
			blue_req <= BLUE_START_DIR;
		end
		else if (round_clear)
		begin
			red_req <= RED_START_DIR;
			blue_req <= BLUE_START_DIR;
		end
		else
		begin
			if (red_turn && red_dir != opposite(red_cur))
				red_req <= red_dir;
			if (blue_turn && blue_dir != opposite(blue_cur))
				blue_req <= blue_dir;
		end
	end

	// advance both heads and hold the record until the arena takes it
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			red_head <= RED_START_DIR;
			blue_head <= BLUE_START_DIR;
			{red_x, red_y} <= {RED_START_X, START_Y};
			{blue_x, blue_y} <= {BLUE_START_X, START_Y};
			move.valid <= 1'b0;
		end
		else if (round_clear)
		begin
			red_head <= RED_START_DIR;
			blue_head <= BLUE_START_DIR;
			{red_x, red_y} <= {RED_START_X, START_Y};
			{blue_x, blue_y} <= {BLUE_START_X, START_Y};
			move.valid <= 1'b0;
		end
		else if (tick_ok)
		begin
			red_head <= red_req;
			blue_head <= blue_req;
			{red_x, red_y} <= red_next;
			{blue_x, blue_y} <= blue_next;
			move.valid <= 1'b1;
		end
		else if (move.ready)
		begin
			move.valid <= 1'b0;
		end
	end

	assign move.red_x = red_x;
	assign move.red_y = red_y;
	assign move.blue_x = blue_x;
	assign move.blue_y = blue_y;

endmodule

/* src/score_pkg.sv */
// Match scoring rules
// Score width, points needed to win and the pause between rounds.

package score_pkg;

	localparam int SCORE_BITS = 2;

	// first player to this many points takes the match
	localparam logic [SCORE_BITS-1:0] WIN_POINTS = 2'd3;

	// frame ticks spent in round_end before the arena is cleared
	localparam logic [1:0] ROUND_PAUSE = 2'd2;

endpackage

/* src/game_pkg.sv */
// Light-cycle game rules
// Arena geometry, headings, game states and start positions shared by the
// steering, arena and control blocks.

package game_pkg;

	// one coordinate, the arena is 16 by 16 and wraps at its edges
	localparam int ARENA_BITS = 4;
	localparam int ARENA_CELLS = 1 << (2 * ARENA_BITS);

	// north decreases y, east increases x
	// opposite headings differ only in bit 1
	typedef enum logic [1:0] {
		north = 2'd0,
		east  = 2'd1,
		south = 2'd2,
		west  = 2'd3
	} dir_t;

	typedef enum logic [1:0] {
		idle      = 2'd0,
		play      = 2'd1,
		round_end = 2'd2,
		match_end = 2'd3
	} game_state_t;

	// both cycles start on the middle row, facing each other
	localparam logic [ARENA_BITS-1:0] RED_START_X = 4'd2;
	localparam logic [ARENA_BITS-1:0] BLUE_START_X = 4'd13;
	localparam logic [ARENA_BITS-1:0] START_Y = 4'd8;

	localparam dir_t RED_START_DIR = east;
	localparam dir_t BLUE_START_DIR = west;

endpackage
